// File: src/hist_defines.svh
`ifndef HIST_DEFINES_SVH
`define HIST_DEFINES_SVH

// ========================================
// Histogram sizing
// ========================================

// Bin index width, 64 bins
`define HIST_BIN_W 6

// Count width per bin
// Counts saturate at all ones
`define HIST_CNT_W 16

// Weight carried by one sample
`define HIST_WGT_W 4

`endif

// File: src/hist_pkg.sv
`include "hist_defines.svh"

package hist_pkg;

   // ========================================
   // Command word
   // ========================================

   // One opcode bit at the top of every command
   typedef enum logic {
      OP_SAMPLE = 1'b0,
      OP_DUMP   = 1'b1
   } cmd_op_e;

   // Sample view, bin and weight follow the opcode
   typedef struct packed {
      cmd_op_e                op;
      logic [`HIST_BIN_W-1:0] bin;
      logic [`HIST_WGT_W-1:0] weight;
   } cmd_sample_t;

   // Control view, rest of word is don't care
   typedef struct packed {
      cmd_op_e                            op;
      logic [`HIST_BIN_W+`HIST_WGT_W-1:0] pad;
   } cmd_ctrl_t;

   // Both views overlay the same 11 bits
   typedef union packed {
      cmd_sample_t smp;
      cmd_ctrl_t   ctl;
   } cmd_u;

   // ========================================
   // RAM requests and result beat
   // ========================================

   // Port A read request
   typedef struct packed {
      logic                   en;
      logic [`HIST_BIN_W-1:0] addr;
   } ram_rd_t;

   // Port B write request
   typedef struct packed {
      logic                   en;
      logic [`HIST_BIN_W-1:0] addr;
      logic [`HIST_CNT_W-1:0] data;
   } ram_wr_t;

   // One bin on the result channel
   // Last marks bin 63
   typedef struct packed {
      logic [`HIST_BIN_W-1:0] bin;
      logic [`HIST_CNT_W-1:0] count;
      logic                   last;
   } dump_beat_t;

endpackage

// File: src/dp_ram.sv
`timescale 1ns/10ps

module dp_ram #(
   parameter RAM_DATA_WIDTH = 16,
   parameter RAM_ADDR_WIDTH = 6
) (
   input  logic                      clk,

   // Port A
   input  logic                      wren_a,
   input  logic [RAM_ADDR_WIDTH-1:0] address_a,
   input  logic [RAM_DATA_WIDTH-1:0] data_a,
   output logic [RAM_DATA_WIDTH-1:0] q_a,

   // Port B
   input  logic                      wren_b,
   input  logic [RAM_ADDR_WIDTH-1:0] address_b,
   input  logic [RAM_DATA_WIDTH-1:0] data_b,
   output logic [RAM_DATA_WIDTH-1:0] q_b
);

   // One word per address value
   localparam RAM_DATA_DEPTH = 2**RAM_ADDR_WIDTH;

   // Shared array, both ports on the one clock
   logic [RAM_DATA_WIDTH-1:0] mem [0:RAM_DATA_DEPTH-1];

   // Port A, write or registered read
   // A read sees the old word if port B writes the same address
   always @(posedge clk) begin
      if (wren_a) begin
         mem[address_a] <= data_a;
      end else begin
         q_a <= mem[address_a];
      end
   end

   // Port B, same behavior as port A
   always @(posedge clk) begin
      if (wren_b) begin
         mem[address_b] <= data_b;
      end else begin
         q_b <= mem[address_b];
      end
   end

endmodule

// File: src/bin_update.sv
`timescale 1ns/10ps
`include "hist_defines.svh"

module bin_update (
   input  logic                   clk,
   input  logic                   reset,

   // Command channel
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   input  hist_pkg::cmd_u         cmd,

   // RAM access
   output hist_pkg::ram_rd_t      rd_req,
   output hist_pkg::ram_wr_t      wr_req,
   input  logic [`HIST_CNT_W-1:0] rd_data,

   // Handoff to the dumper
   output logic                   dump_start,
   input  logic                   dump_busy
);

   // Run accepts commands, drain empties stage 2, wait covers the dump
   typedef enum logic [1:0] {
      ST_RUN,
      ST_DRAIN,
      ST_WAIT
   } state_e;

   state_e                 state;
   logic                   cmd_xfer;
   logic                   is_sample;
   logic                   is_dump;

   // Stage 2, count returns from port A here
   logic                   s2_valid;
   logic [`HIST_BIN_W-1:0] s2_bin;
   logic [`HIST_WGT_W-1:0] s2_weight;

   // Last write, covers a read that raced it
   logic                   fwd_valid;
   logic [`HIST_BIN_W-1:0] fwd_bin;
   logic [`HIST_CNT_W-1:0] fwd_cnt;

   // Add and saturate
   logic [`HIST_CNT_W-1:0] base_cnt;
   logic [`HIST_CNT_W:0]   sum_wide;
   logic [`HIST_CNT_W-1:0] sum_sat;

   // ========================================
   // Command decode
   // ========================================

   assign cmd_ready = (state == ST_RUN);
   assign cmd_xfer  = cmd_valid && cmd_ready;

   // Dump only needs the control view
   assign is_dump   = cmd_xfer && (cmd.ctl.op == hist_pkg::OP_DUMP);
   assign is_sample = cmd_xfer && (cmd.smp.op == hist_pkg::OP_SAMPLE);

   // Read goes out on the accept edge
   assign rd_req.en   = is_sample;
   assign rd_req.addr = cmd.smp.bin;

   // ========================================
   // Stage 2 add
   // ========================================

   // Read issued together with the previous write returns stale data
   assign base_cnt = (fwd_valid && (fwd_bin == s2_bin)) ? fwd_cnt : rd_data;

   assign sum_wide = {1'b0, base_cnt}
                   + {{(`HIST_CNT_W - `HIST_WGT_W + 1){1'b0}}, s2_weight};

   // Carry out means overflow, clamp to all ones
   assign sum_sat = sum_wide[`HIST_CNT_W] ? {`HIST_CNT_W{1'b1}}
                                          : sum_wide[`HIST_CNT_W-1:0];

   // Write lands on the edge that ends stage 2
   assign wr_req.en   = s2_valid;
   assign wr_req.addr = s2_bin;
   assign wr_req.data = sum_sat;

   // Start the dump once nothing is left to write
   assign dump_start = (state == ST_DRAIN) && !s2_valid;

   // Pipeline payload
   always_ff @(posedge clk) begin
      if (is_sample) begin
         s2_bin    <= cmd.smp.bin;
         s2_weight <= cmd.smp.weight;
      end
      if (s2_valid) begin
         fwd_bin <= s2_bin;
         fwd_cnt <= sum_sat;
      end
   end

   // Pipeline valids
   // Forward entry lives one cycle, memory holds it after that
   always_ff @(posedge clk) begin
      if (reset) begin
         s2_valid  <= 1'b0;
         fwd_valid <= 1'b0;
      end else begin
         s2_valid  <= is_sample;
         fwd_valid <= s2_valid;
      end
   end

   // ========================================
   // Command FSM
   // ========================================

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_RUN;
      end else begin
         case (state)
            ST_RUN: begin
               if (is_dump) begin
                  state <= ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               if (!s2_valid) begin
                  state <= ST_WAIT;
               end
            end
            // Busy is already high on the first wait cycle
            ST_WAIT: begin
               if (!dump_busy) begin
                  state <= ST_RUN;
               end
            end
            default: begin
               state <= ST_RUN;
            end
         endcase
      end
   end

endmodule

// File: src/bin_dump.sv
`timescale 1ns/10ps
`include "hist_defines.svh"

module bin_dump (
   input  logic                   clk,
   input  logic                   reset,

   // Handoff from the updater
   input  logic                   dump_start,
   output logic                   dump_busy,
   output logic                   dump_done,

   // RAM access
   output hist_pkg::ram_rd_t      rd_req,
   output hist_pkg::ram_wr_t      wr_req,
   input  logic [`HIST_CNT_W-1:0] rd_data,

   // Result channel
   output logic                   out_valid,
   input  logic                   out_ready,
   output hist_pkg::dump_beat_t   out
);

   // Read waits on port A data, hold waits on out_ready
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_HOLD
   } state_e;

   state_e                 state;
   logic [`HIST_BIN_W-1:0] bin;
   // Set once the read of bin is in flight
   logic                   rd_live;
   logic                   beat_xfer;
   logic                   last_bin;

   assign out_valid = (state == ST_HOLD);
   assign dump_busy = (state != ST_IDLE);
   assign beat_xfer = out_valid && out_ready;
   assign last_bin  = (bin == {`HIST_BIN_W{1'b1}});

   // ========================================
   // RAM requests
   // ========================================

   // First bin reads from the read state, later bins on the handshake
   assign rd_req.en   = ((state == ST_READ) && !rd_live)
                     || (beat_xfer && !last_bin);
   assign rd_req.addr = (state == ST_HOLD) ? bin + 1'b1 : bin;

   // Clear the bin just sent
   assign wr_req.en   = beat_xfer;
   assign wr_req.addr = bin;
   assign wr_req.data = '0;

   // Capture the beat the cycle after its read
   always_ff @(posedge clk) begin
      if ((state == ST_READ) && rd_live) begin
         out.bin   <= bin;
         out.count <= rd_data;
         out.last  <= last_bin;
      end
   end

   // ========================================
   // Walk FSM
   // ========================================

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= ST_IDLE;
         bin       <= '0;
         rd_live   <= 1'b0;
         dump_done <= 1'b0;
      end else begin
         dump_done <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (dump_start) begin
                  state   <= ST_READ;
                  bin     <= '0;
                  rd_live <= 1'b0;
               end
            end
            ST_READ: begin
               if (rd_live) begin
                  state <= ST_HOLD;
               end else begin
                  rd_live <= 1'b1;
               end
            end
            ST_HOLD: begin
               if (beat_xfer) begin
                  if (last_bin) begin
                     // Bin 63 cleared on this edge
                     state     <= ST_IDLE;
                     dump_done <= 1'b1;
                  end else begin
                     state   <= ST_READ;
                     bin     <= bin + 1'b1;
                     rd_live <= 1'b1;
                  end
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

// File: src/hist_top.sv
`timescale 1ns/10ps
`include "hist_defines.svh"

module hist_top (
   input  logic                 clk,
   input  logic                 reset,

   // Command channel
   input  logic                 cmd_valid,
   output logic                 cmd_ready,
   input  hist_pkg::cmd_u       cmd,

   // Result channel
   output logic                 out_valid,
   input  logic                 out_ready,
   output hist_pkg::dump_beat_t out
);

   // Requests from each side, and what reaches the RAM
   hist_pkg::ram_rd_t      upd_rd;
   hist_pkg::ram_wr_t      upd_wr;
   hist_pkg::ram_rd_t      dmp_rd;
   hist_pkg::ram_wr_t      dmp_wr;
   hist_pkg::ram_rd_t      ram_rd;
   hist_pkg::ram_wr_t      ram_wr;

   // Port A data goes to both sides
   logic [`HIST_CNT_W-1:0] rd_data;
   logic                   dump_start;
   logic                   dump_busy;

   // ========================================
   // Updater and dumper
   // ========================================

   bin_update u_update (
      .clk        (clk),
      .reset      (reset),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd        (cmd),
      .rd_req     (upd_rd),
      .wr_req     (upd_wr),
      .rd_data    (rd_data),
      .dump_start (dump_start),
      .dump_busy  (dump_busy)
   );

   // Done pulse is for observation only
   bin_dump u_dump (
      .clk        (clk),
      .reset      (reset),
      .dump_start (dump_start),
      .dump_busy  (dump_busy),
      .dump_done  (),
      .rd_req     (dmp_rd),
      .wr_req     (dmp_wr),
      .rd_data    (rd_data),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out        (out)
   );

   // ========================================
   // RAM port routing
   // ========================================

   // Dumper owns both ports while busy
   assign ram_rd = dump_busy ? dmp_rd : upd_rd;
   assign ram_wr = dump_busy ? dmp_wr : upd_wr;

   // Port A reads only, port B writes only
   dp_ram #(
      .RAM_DATA_WIDTH (`HIST_CNT_W),
      .RAM_ADDR_WIDTH (`HIST_BIN_W)
   ) u_ram (
      .clk       (clk),
      .wren_a    (1'b0),
      .address_a (ram_rd.addr),
      .data_a    ({`HIST_CNT_W{1'b0}}),
      .q_a       (rd_data),
      .wren_b    (ram_wr.en),
      .address_b (ram_wr.addr),
      .data_b    (ram_wr.data),
      .q_b       ()
   );

endmodule

// File: tb/hist_tb.sv
`timescale 1ns/10ps
`include "hist_defines.svh"

module hist_tb;

   localparam int NUM_BINS      = 1 << `HIST_BIN_W;
   localparam int CNT_MAX       = (1 << `HIST_CNT_W) - 1;
   localparam int CMD_WAIT_MAX  = 5000;
   localparam int DUMP_WAIT_MAX = 5000;

   logic                 clk;
   logic                 reset;
   logic                 cmd_valid;
   logic                 cmd_ready;
   hist_pkg::cmd_u       cmd;
   logic                 out_valid;
   logic                 out_ready;
   hist_pkg::dump_beat_t out_beat;

   // Generator state, one stream for stimulus and one for stalls
   int unsigned          stim_seed;
   int unsigned          stall_seed;

   // Reference histogram
   int unsigned          model [0:NUM_BINS-1];

   int                   value_errs;
   int                   timeout_errs;
   int                   dumps_seen;
   logic [`HIST_BIN_W-1:0] exp_bin;
   bit                   stall_en;
   bit                   check_counts;
   string                test_name;

   hist_top UUT (
      .clk       (clk),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd       (cmd),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out       (out_beat)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ========================================
   // Helpers
   // ========================================

   function automatic int unsigned lcg_step(input int unsigned s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // Upper bits are the better random ones
   function int unsigned next_rand();
      stim_seed = lcg_step(stim_seed);
      return stim_seed >> 16;
   endfunction

   // Expected count after one sample, clamped at all ones
   function automatic int unsigned sat_add(input int unsigned cnt, input int unsigned w);
      int unsigned sum;
      sum = cnt + w;
      return (sum > CNT_MAX) ? CNT_MAX : sum;
   endfunction

   function automatic int unsigned ref_count(input int unsigned bin);
      return model[bin];
   endfunction

   function automatic hist_pkg::cmd_u make_sample(input int unsigned b, input int unsigned w);
      hist_pkg::cmd_u c;
      c.smp.op     = hist_pkg::OP_SAMPLE;
      c.smp.bin    = b[`HIST_BIN_W-1:0];
      c.smp.weight = w[`HIST_WGT_W-1:0];
      return c;
   endfunction

   function automatic hist_pkg::cmd_u make_dump();
      hist_pkg::cmd_u c;
      c.ctl.op  = hist_pkg::OP_DUMP;
      c.ctl.pad = '0;
      return c;
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      value_errs++;
      $display("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
   endtask

   task automatic finish_run();
      $display("Summary: %0d value errors, %0d timeouts", value_errs, timeout_errs);
      if (value_errs + timeout_errs == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   endtask

   task automatic timeout_fail(input string what);
      timeout_errs++;
      $display("Timeout in %s while waiting for %s", test_name, what);
      finish_run();
   endtask

   // Shared flags change only right after a rising edge
   task automatic begin_test(input string name, input bit stalls, input bit counts);
      @(posedge clk);
      test_name    = name;
      stall_en     = stalls;
      check_counts = counts;
      @(negedge clk);
   endtask

   // Called at a falling edge, returns at the falling edge after the transfer
   task automatic send_cmd(input hist_pkg::cmd_u c);
      int waited;
      waited    = 0;
      cmd       = c;
      cmd_valid = 1'b1;
      while (!cmd_ready && waited < CMD_WAIT_MAX) begin
         @(negedge clk);
         waited++;
      end
      if (!cmd_ready) begin
         timeout_fail("cmd_ready");
      end
      // Ready is steady here, so the word goes in on the next rising edge
      if (c.smp.op == hist_pkg::OP_SAMPLE) begin
         model[c.smp.bin] = sat_add(model[c.smp.bin], c.smp.weight);
      end
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   // Dump command, all 64 beats, then ready back
   task automatic run_dump();
      int target;
      int waited;
      target = dumps_seen + 1;
      send_cmd(make_dump());
      waited = 0;
      while (dumps_seen < target && waited < DUMP_WAIT_MAX) begin
         @(posedge clk);
         waited++;
      end
      if (dumps_seen < target) begin
         timeout_fail("the last dump beat");
      end
      @(negedge clk);
      waited = 0;
      while (!cmd_ready && waited < CMD_WAIT_MAX) begin
         @(negedge clk);
         waited++;
      end
      if (!cmd_ready) begin
         timeout_fail("cmd_ready after the dump");
      end
   endtask

   // ========================================
   // Result channel compare
   // ========================================

   task automatic check_beat();
      int unsigned exp_cnt;
      exp_cnt = ref_count(exp_bin);
      if (out_beat.bin !== exp_bin) begin
         report_mismatch("bin", exp_bin, out_beat.bin);
      end
      if (check_counts && out_beat.count !== exp_cnt[`HIST_CNT_W-1:0]) begin
         report_mismatch($sformatf("count of bin %0d", exp_bin), exp_cnt, out_beat.count);
      end
      if (out_beat.last !== (exp_bin == NUM_BINS - 1)) begin
         report_mismatch($sformatf("last of bin %0d", exp_bin),
                         exp_bin == NUM_BINS - 1, out_beat.last);
      end
      // Bin is cleared behind the beat
      model[exp_bin] = 0;
      if (exp_bin == NUM_BINS - 1) begin
         dumps_seen++;
      end
      exp_bin = exp_bin + 1'b1;
   endtask

   // Ready chosen first, then the beat that goes on the next rising edge
   always @(negedge clk) begin
      if (!reset) begin
         if (stall_en) begin
            stall_seed = lcg_step(stall_seed);
            out_ready  = ((stall_seed >> 16) % 4) != 0;
         end else begin
            out_ready = 1'b1;
         end
         if (out_valid && out_ready) begin
            check_beat();
         end
      end
   end

   // ========================================
   // Stimulus
   // ========================================

   initial begin
      int unsigned b;
      int unsigned w;
      int target;
      reset        = 1'b1;
      cmd_valid    = 1'b0;
      cmd          = '0;
      out_ready    = 1'b0;
      stim_seed    = 37;
      stall_seed   = 37;
      value_errs   = 0;
      timeout_errs = 0;
      dumps_seen   = 0;
      exp_bin      = '0;
      stall_en     = 1'b0;
      check_counts = 1'b0;
      test_name    = "reset";
      for (int i = 0; i < NUM_BINS; i++) begin
         model[i] = 0;
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      if (cmd_ready !== 1'b1) begin
         report_mismatch("cmd_ready", 1, cmd_ready);
      end
      if (out_valid !== 1'b0) begin
         report_mismatch("out_valid", 0, out_valid);
      end

      // Memory starts unknown, first dump only clears it
      begin_test("initial_clear", 1'b0, 1'b0);
      run_dump();
      begin_test("zero_dump", 1'b0, 1'b1);
      run_dump();

      // Random bins and weights with gaps of 0 to 3
      begin_test("random_samples", 1'b0, 1'b1);
      repeat (300) begin
         b = next_rand();
         w = next_rand();
         send_cmd(make_sample(b, w));
         repeat (next_rand() % 4) @(negedge clk);
      end
      run_dump();

      // Same bin every cycle, then two bins alternating
      begin_test("forwarding", 1'b0, 1'b1);
      for (int i = 0; i < 24; i++) begin
         send_cmd(make_sample(5, i % 16));
      end
      for (int i = 0; i < 24; i++) begin
         send_cmd(make_sample((i % 2) ? 11 : 10, 15 - (i % 16)));
      end
      // Two-cycle reuse reads memory
      for (int i = 0; i < 18; i++) begin
         send_cmd(make_sample((i % 3 == 2) ? 21 : 20, i % 16));
      end
      run_dump();

      begin_test("saturation", 1'b0, 1'b1);
      repeat (CNT_MAX / 15 + 20) begin
         send_cmd(make_sample(42, 15));
      end
      run_dump();

      // Stalled dump with a sample held behind it
      begin_test("stalled_dump", 1'b1, 1'b1);
      repeat (40) begin
         b = next_rand();
         w = next_rand();
         send_cmd(make_sample(b, w));
      end
      target = dumps_seen + 1;
      send_cmd(make_dump());
      send_cmd(make_sample(7, 9));
      if (dumps_seen != target) begin
         value_errs++;
         $display("Sample was accepted before the running dump finished");
      end
      begin_test("held_sample", 1'b1, 1'b1);
      run_dump();
      begin_test("final_zero", 1'b0, 1'b1);
      run_dump();

      finish_run();
   end

endmodule

// File: hist.f
+incdir+src
src/hist_pkg.sv
src/dp_ram.sv
src/bin_update.sv
src/bin_dump.sv
src/hist_top.sv
tb/hist_tb.sv
